// File: common/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    localparam word_t RESET_PC  = 32'hbfc0_0000;
    // sll $0,$0,0 decodes as a nop
    localparam word_t NOP_INSTR = 32'h0000_0000;

endpackage

// File: hdl/regfile.sv
module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata,
    input  mips_pkg::reg_addr_t raddr_a,
    input  mips_pkg::reg_addr_t raddr_b,
    output mips_pkg::word_t     rdata_a,
    output mips_pkg::word_t     rdata_b
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // $0 is hardwired, a write in flight is seen by decode
    always_comb begin
        if (raddr_a == 5'd0) begin
            rdata_a = '0;
        end else if (we && raddr_a == waddr) begin
            rdata_a = wdata;
        end else begin
            rdata_a = regs[raddr_a];
        end
        if (raddr_b == 5'd0) begin
            rdata_b = '0;
        end else if (we && raddr_b == waddr) begin
            rdata_b = wdata;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

endmodule

// File: hdl/hazard_unit.sv
module hazard_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t rs_d,
    input  mips_pkg::reg_addr_t rt_d,
    input  mips_pkg::reg_addr_t rs_e,
    input  mips_pkg::reg_addr_t rt_e,
    input  mips_pkg::reg_addr_t dst_e,
    input  logic                is_load_e,
    input  mips_pkg::reg_addr_t dst_m,
    input  logic                reg_we_m,
    input  mips_pkg::reg_addr_t dst_w,
    input  logic                reg_we_w,
    input  logic                branch_taken,
    input  logic                i_data_ok,
    input  logic                d_data_ok,
    input  logic                mem_access,
    output logic                stall_f,
    output logic                stall_d,
    output logic                flush_d,
    output logic                flush_e,
    output logic                stall_all,
    output mips_pkg::fwd_sel_t  fwd_a,
    output mips_pkg::fwd_sel_t  fwd_b
);
    import mips_pkg::*;

    logic load_use;

    // memory stage has the newer value, so it is checked first
    function automatic fwd_sel_t pick_src(input reg_addr_t src);
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (src != 5'd0 && reg_we_m && dst_m == src) begin
            sel = FWD_MEM;
        end else if (src != 5'd0 && reg_we_w && dst_w == src) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a = pick_src(rs_e);
    assign fwd_b = pick_src(rt_e);

    assign load_use  = is_load_e && dst_e != 5'd0 && (dst_e == rs_d || dst_e == rt_d);
    assign stall_all = mem_access && !d_data_ok;

    // a redirect still has to load the target while the fetch is not ok
    assign stall_f = stall_all || load_use || (!i_data_ok && !branch_taken);
    assign stall_d = stall_all || load_use;
    assign flush_d = !stall_d && (branch_taken || !i_data_ok);
    assign flush_e = !stall_all && (branch_taken || load_use);

    // a flush held back by a memory stall still happens once the stall ends
    a_flush_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall_all && (branch_taken || load_use) |=> stall_all || flush_e);

endmodule

// File: pipeline/fetch_stage.sv
module fetch_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall_f,
    input  logic            branch_taken,
    input  mips_pkg::word_t branch_target,
    output mips_pkg::word_t pc
);
    import mips_pkg::*;

    word_t pc_next;

    // taken beq wins over sequential flow, no delay slot
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!stall_f) begin
            pc <= pc_next;
        end
    end

endmodule

// File: pipeline/decode_stage.sv
module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_d,
    input  logic                flush_d,
    input  mips_pkg::word_t     instr_,
    input  mips_pkg::word_t     pc_f,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    output mips_pkg::reg_addr_t rs_addr,
    output mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::reg_addr_t dst_addr,
    output mips_pkg::word_t     pc_d,
    output mips_pkg::word_t     imm_ext,
    output mips_pkg::word_t     rs_val,
    output mips_pkg::word_t     rt_val,
    output mips_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output logic                reg_we,
    output logic                is_load,
    output logic                is_store,
    output logic                is_branch,
    output logic                valid_d
);
    import mips_pkg::*;

    word_t   instr_d;
    opcode_t opcode;
    funct_t  funct;

    // IF/ID register, a bubble is the nop word with valid cleared
    always_ff @(posedge clk) begin
        if (!rst_n || flush_d) begin
            instr_d <= NOP_INSTR;
            valid_d <= 1'b0;
        end else if (!stall_d) begin
            instr_d <= instr_;
            pc_d    <= pc_f;
            valid_d <= 1'b1;
        end
    end

    assign opcode  = opcode_t'(instr_d[31:26]);
    assign funct   = funct_t'(instr_d[5:0]);
    assign rs_addr = instr_d[25:21];
    assign rt_addr = instr_d[20:16];
    assign imm_ext = {{16{instr_d[15]}}, instr_d[15:0]};

    // regfile already bypasses a same-cycle write
    assign rs_val = rs_data;
    assign rt_val = rt_data;

    always_comb begin
        alu_op    = ALU_ADD;
        dst_addr  = instr_d[20:16];
        use_imm   = 1'b0;
        reg_we    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dst_addr = instr_d[15:11];
                reg_we   = 1'b1;
                case (funct)
                    F_ADDU:  alu_op = ALU_ADD;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_SLT:   alu_op = ALU_SLT;
                    default: reg_we = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            OP_LW: begin
                use_imm = 1'b1;
                reg_we  = 1'b1;
                is_load = 1'b1;
            end
            OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            OP_BEQ: begin
                alu_op    = ALU_SUB;
                is_branch = 1'b1;
            end
            // anything else falls through as a nop
            default: ;
        endcase
    end

endmodule

// File: pipeline/execute_stage.sv
module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_e,
    input  logic                stall_all,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  mips_pkg::reg_addr_t dst_addr,
    input  mips_pkg::word_t     pc_d,
    input  mips_pkg::word_t     imm_ext,
    input  mips_pkg::word_t     rs_val,
    input  mips_pkg::word_t     rt_val,
    input  mips_pkg::alu_op_t   alu_op,
    input  logic                use_imm,
    input  logic                reg_we,
    input  logic                is_load,
    input  logic                is_store,
    input  logic                is_branch,
    input  logic                valid_d,
    input  mips_pkg::fwd_sel_t  fwd_a,
    input  mips_pkg::fwd_sel_t  fwd_b,
    input  mips_pkg::word_t     mem_fwd,
    input  mips_pkg::word_t     wb_fwd,
    output logic                branch_taken,
    output mips_pkg::word_t     branch_target,
    output mips_pkg::word_t     alu_result,
    output mips_pkg::word_t     store_data,
    output mips_pkg::word_t     pc_e,
    output mips_pkg::reg_addr_t dst_e,
    output mips_pkg::reg_addr_t rs_e,
    output mips_pkg::reg_addr_t rt_e,
    output logic                reg_we_e,
    output logic                is_load_e,
    output logic                is_store_e,
    output logic                valid_e
);
    import mips_pkg::*;

    word_t   imm_e, rs_val_e, rt_val_e, src_a, src_b, alu_b;
    alu_op_t alu_op_e;
    logic    use_imm_e, is_branch_e;

    // ID/EX register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_we_e    <= 1'b0;
            is_load_e   <= 1'b0;
            is_store_e  <= 1'b0;
            is_branch_e <= 1'b0;
            valid_e     <= 1'b0;
        end else if (stall_all) begin
            // writeback empties during the stall, so keep the forwarded operands
            rs_val_e <= src_a;
            rt_val_e <= src_b;
        end else if (flush_e) begin
            reg_we_e    <= 1'b0;
            is_load_e   <= 1'b0;
            is_store_e  <= 1'b0;
            is_branch_e <= 1'b0;
            valid_e     <= 1'b0;
        end else begin
            rs_e        <= rs_addr;
            rt_e        <= rt_addr;
            dst_e       <= dst_addr;
            pc_e        <= pc_d;
            imm_e       <= imm_ext;
            rs_val_e    <= rs_val;
            rt_val_e    <= rt_val;
            alu_op_e    <= alu_op;
            use_imm_e   <= use_imm;
            reg_we_e    <= reg_we;
            is_load_e   <= is_load;
            is_store_e  <= is_store;
            is_branch_e <= is_branch;
            valid_e     <= valid_d;
        end
    end

    // forwarding muxes
    always_comb begin
        case (fwd_a)
            FWD_MEM: src_a = mem_fwd;
            FWD_WB:  src_a = wb_fwd;
            default: src_a = rs_val_e;
        endcase
        case (fwd_b)
            FWD_MEM: src_b = mem_fwd;
            FWD_WB:  src_b = wb_fwd;
            default: src_b = rt_val_e;
        endcase
    end

    assign alu_b      = use_imm_e ? imm_e : src_b;
    assign store_data = src_b;

    always_comb begin
        case (alu_op_e)
            ALU_SUB: alu_result = src_a - alu_b;
            ALU_AND: alu_result = src_a & alu_b;
            ALU_OR:  alu_result = src_a | alu_b;
            ALU_SLT: alu_result = {31'd0, $signed(src_a) < $signed(alu_b)};
            default: alu_result = src_a + alu_b;
        endcase
    end

    // beq resolves here
    assign branch_taken  = is_branch_e && (src_a == src_b);
    assign branch_target = pc_e + 32'd4 + {imm_e[29:0], 2'b00};

endmodule

// File: pipeline/memory_stage.sv
module memory_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_all,
    input  logic                d_data_ok,
    input  mips_pkg::word_t     alu_result,
    input  mips_pkg::word_t     store_data,
    input  mips_pkg::word_t     pc_e,
    input  mips_pkg::reg_addr_t dst_e,
    input  logic                reg_we_e,
    input  logic                is_load_e,
    input  logic                is_store_e,
    input  logic                valid_e,
    input  mips_pkg::word_t     rd,
    output logic                mem_ren,
    output logic                mem_wen,
    output mips_pkg::word_t     mem_addr,
    output mips_pkg::word_t     mem_wdata,
    output mips_pkg::word_t     mem_fwd,
    output mips_pkg::reg_addr_t dst_m,
    output logic                reg_we_m,
    output logic                wb_valid,
    output logic                rf_we,
    output mips_pkg::word_t     wb_pc,
    output mips_pkg::word_t     rf_wdata,
    output mips_pkg::reg_addr_t rf_waddr
);
    import mips_pkg::*;

    word_t pc_m;
    logic  valid_m, mem_done;

    // EX/MEM register drives the data port directly
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ren  <= 1'b0;
            mem_wen  <= 1'b0;
            reg_we_m <= 1'b0;
            valid_m  <= 1'b0;
        end else if (!stall_all) begin
            mem_ren   <= is_load_e;
            mem_wen   <= is_store_e;
            mem_addr  <= alu_result;
            mem_wdata <= store_data;
            dst_m     <= dst_e;
            pc_m      <= pc_e;
            reg_we_m  <= reg_we_e;
            valid_m   <= valid_e;
        end
    end

    assign mem_fwd  = mem_addr;
    assign mem_done = !(mem_ren || mem_wen) || d_data_ok;

    // MEM/WB register, bubble while the access is pending
    always_ff @(posedge clk) begin
        if (!rst_n || !mem_done) begin
            wb_valid <= 1'b0;
            rf_we    <= 1'b0;
        end else begin
            wb_valid <= valid_m;
            rf_we    <= reg_we_m && (dst_m != 5'd0);
            rf_waddr <= dst_m;
            wb_pc    <= pc_m;
            rf_wdata <= mem_ren ? rd : mem_addr;
        end
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_ren && mem_wen));

endmodule

// File: hdl/mips_core.sv
module mips_core (
    input  logic                clk,
    input  logic                rst_n,
    output mips_pkg::word_t     pc,
    input  mips_pkg::word_t     instr_,
    input  logic                i_data_ok,
    output logic                mem_ren,
    output logic                mem_wen,
    output mips_pkg::word_t     mem_addr,
    output mips_pkg::word_t     mem_wdata,
    input  mips_pkg::word_t     rd,
    input  logic                d_data_ok,
    output logic                wb_valid,
    output mips_pkg::word_t     wb_pc,
    output logic                rf_we,
    output mips_pkg::reg_addr_t rf_waddr,
    output mips_pkg::word_t     rf_wdata,
    output logic                stallF
);
    import mips_pkg::*;

    // hazard controls
    logic      stall_d, flush_d, flush_e, stall_all;
    fwd_sel_t  fwd_a, fwd_b;

    // decode to execute
    reg_addr_t rs_addr, rt_addr, dst_addr;
    word_t     pc_d, imm_ext, rs_val, rt_val, rs_data, rt_data;
    alu_op_t   alu_op;
    logic      use_imm, reg_we, is_load, is_store, is_branch, valid_d;

    // execute to memory and fetch
    logic      branch_taken;
    word_t     branch_target, alu_result, store_data, pc_e, mem_fwd;
    reg_addr_t dst_e, rs_e, rt_e, dst_m;
    logic      reg_we_e, is_load_e, is_store_e, valid_e, reg_we_m;

    fetch_stage u_fetch (
        .clk, .rst_n, .stall_f(stallF), .branch_taken, .branch_target, .pc
    );

    decode_stage u_decode (
        .clk, .rst_n, .stall_d, .flush_d, .instr_, .pc_f(pc), .rs_data, .rt_data,
        .rs_addr, .rt_addr, .dst_addr, .pc_d, .imm_ext, .rs_val, .rt_val, .alu_op,
        .use_imm, .reg_we, .is_load, .is_store, .is_branch, .valid_d
    );

    execute_stage u_execute (
        .clk, .rst_n, .flush_e, .stall_all,
        .rs_addr, .rt_addr, .dst_addr, .pc_d, .imm_ext, .rs_val, .rt_val, .alu_op,
        .use_imm, .reg_we, .is_load, .is_store, .is_branch, .valid_d,
        .fwd_a, .fwd_b, .mem_fwd, .wb_fwd(rf_wdata),
        .branch_taken, .branch_target, .alu_result, .store_data, .pc_e,
        .dst_e, .rs_e, .rt_e, .reg_we_e, .is_load_e, .is_store_e, .valid_e
    );

    memory_stage u_memory (
        .clk, .rst_n, .stall_all, .d_data_ok,
        .alu_result, .store_data, .pc_e, .dst_e, .reg_we_e, .is_load_e, .is_store_e,
        .valid_e, .rd, .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_fwd, .dst_m,
        .reg_we_m, .wb_valid, .rf_we, .wb_pc, .rf_wdata, .rf_waddr
    );

    regfile u_regfile (
        .clk, .rst_n, .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr_a(rs_addr), .raddr_b(rt_addr), .rdata_a(rs_data), .rdata_b(rt_data)
    );

    hazard_unit u_hazard (
        .clk, .rst_n, .rs_d(rs_addr), .rt_d(rt_addr), .rs_e, .rt_e, .dst_e,
        .is_load_e, .dst_m, .reg_we_m, .dst_w(rf_waddr), .reg_we_w(rf_we),
        .branch_taken, .i_data_ok, .d_data_ok, .mem_access(mem_ren | mem_wen),
        .stall_f(stallF), .stall_d, .flush_d, .flush_e, .stall_all, .fwd_a, .fwd_b
    );

endmodule

// File: tb/tb_mips_core.sv
module tb_mips_core;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_pkg::*;

    localparam int NUM_ROWS        = 27;
    localparam int NUM_PASSES      = 2;
    localparam int WATCHDOG_CYCLES = NUM_PASSES * NUM_ROWS * 20;
    // lw $10 followed by addu on $10 is the only load-use pair
    localparam int LOAD_USE_STALLS = 1;

    logic      clk;
    logic      rst_n;
    word_t     pc;
    word_t     instr_;
    logic      i_data_ok;
    logic      mem_ren;
    logic      mem_wen;
    word_t     mem_addr;
    word_t     mem_wdata;
    word_t     rd;
    logic      d_data_ok;
    logic      wb_valid;
    word_t     wb_pc;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    logic      stallF;

    // program table, one entry per instruction word
    word_t prog_instr[$];
    int    prog_dst[$];
    word_t prog_value[$];
    int    exp_rows[$];

    word_t  dmem [16];
    word_t  dmem_expect [16];
    word_t  imem_idx;
    integer seed = 32'hbd5a_d9f4;
    int     errors;
    int     checks;

    mips_core UUT (
        .clk, .rst_n, .pc, .instr_, .i_data_ok, .mem_ren, .mem_wen, .mem_addr,
        .mem_wdata, .rd, .d_data_ok, .wb_valid, .wb_pc, .rf_we, .rf_waddr,
        .rf_wdata, .stallF
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t encode_r(input funct_t funct, input int rs, input int rt,
                                       input int rdst);
        return {OP_RTYPE, rs[4:0], rt[4:0], rdst[4:0], 5'd0, funct};
    endfunction

    function automatic word_t encode_i(input opcode_t op, input int rs, input int rt,
                                       input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // fill value mixes every address bit
    function automatic word_t preset_word(input word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'hc0de_5a5a;
    endfunction

    // instruction memory, returns junk while the fetch is not ok
    always_comb begin
        imem_idx = (pc - RESET_PC) >> 2;
        if (!i_data_ok) begin
            instr_ = 32'hffff_ffff;
        end else if (imem_idx < prog_instr.size()) begin
            instr_ = prog_instr[imem_idx];
        end else begin
            instr_ = NOP_INSTR;
        end
    end

    // data memory, 16 words from address 0
    always_comb begin
        if (d_data_ok) begin
            rd = dmem[mem_addr[5:2]];
        end else begin
            rd = 32'hdead_beef;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                dmem[i[3:0]] <= preset_word(word_t'(i * 4));
            end
        end else if (mem_wen && d_data_ok) begin
            dmem[mem_addr[5:2]] <= mem_wdata;
        end
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic add_row(input word_t instr, input bit retires, input int dst,
                           input word_t value);
        if (retires) begin
            exp_rows.push_back(prog_instr.size());
        end
        prog_instr.push_back(instr);
        prog_dst.push_back(dst);
        prog_value.push_back(value);
    endtask

    // expected values worked out by hand from the MIPS rules
    task automatic build_program();
        word_t ld = preset_word(32'h10);
        add_row(encode_i(OP_ADDIU, 0, 1, 5), 1, 1, 32'h0000_0005);
        add_row(encode_i(OP_ADDIU, 0, 2, -3), 1, 2, 32'hffff_fffd);
        add_row(encode_r(F_ADDU, 1, 2, 3), 1, 3, 32'h0000_0002);
        add_row(encode_r(F_SUBU, 2, 1, 4), 1, 4, 32'hffff_fff8);
        add_row(encode_r(F_SLT, 2, 1, 5), 1, 5, 32'h0000_0001);
        add_row(encode_r(F_SLT, 1, 2, 6), 1, 6, 32'h0000_0000);
        add_row(encode_r(F_AND, 1, 4, 7), 1, 7, 32'h0000_0000);
        add_row(encode_r(F_OR, 1, 4, 8), 1, 8, 32'hffff_fffd);
        add_row(encode_i(OP_ADDIU, 0, 9, 32), 1, 9, 32'h0000_0020);
        add_row(encode_i(OP_SW, 9, 8, 4), 1, 0, 32'h0);
        add_row(encode_i(OP_LW, 9, 10, 4), 1, 10, 32'hffff_fffd);
        // load-use on $10
        add_row(encode_r(F_ADDU, 10, 1, 11), 1, 11, 32'h0000_0002);
        add_row(encode_i(OP_LW, 0, 12, 16), 1, 12, ld);
        // write to $0 must not show up
        add_row(encode_i(OP_ADDIU, 0, 0, 7), 1, 0, 32'h0);
        add_row(encode_r(F_ADDU, 0, 0, 13), 1, 13, 32'h0000_0000);
        add_row(encode_i(OP_BEQ, 1, 2, 5), 1, 0, 32'h0);
        add_row(encode_i(OP_ADDIU, 12, 14, 1), 1, 14, ld + 32'd1);
        // newer value in memory stage beats writeback
        add_row(encode_i(OP_ADDIU, 0, 19, 1), 1, 19, 32'h0000_0001);
        add_row(encode_i(OP_ADDIU, 19, 19, 1), 1, 19, 32'h0000_0002);
        add_row(encode_r(F_ADDU, 19, 19, 20), 1, 20, 32'h0000_0004);
        add_row(encode_i(OP_BEQ, 3, 3, 2), 1, 0, 32'h0);
        add_row(encode_i(OP_ADDIU, 0, 15, 1), 0, 15, 32'h0000_0001);
        add_row(encode_i(OP_ADDIU, 0, 16, 2), 0, 16, 32'h0000_0002);
        add_row(encode_i(OP_ADDIU, 3, 17, 100), 1, 17, 32'h0000_0066);
        add_row(encode_i(OP_SW, 9, 17, 0), 1, 0, 32'h0);
        add_row(encode_i(OP_LW, 9, 18, 0), 1, 18, 32'h0000_0066);
        // spin on itself
        add_row(encode_i(OP_BEQ, 0, 0, -1), 1, 0, 32'h0);
        for (int i = 0; i < 16; i++) begin
            dmem_expect[i[3:0]] = preset_word(word_t'(i * 4));
        end
        dmem_expect[8] = 32'h0000_0066;
        dmem_expect[9] = 32'hffff_fffd;
    endtask

    task automatic apply_reset(input string tag);
        rst_n     = 1'b0;
        i_data_ok = 1'b1;
        d_data_ok = 1'b1;
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        check_value({tag, " reset pc"}, RESET_PC, pc);
        check_value({tag, " reset wb_valid"}, 32'd0, {31'd0, wb_valid});
        check_value({tag, " reset rf_we"}, 32'd0, {31'd0, rf_we});
        check_value({tag, " reset mem_ren"}, 32'd0, {31'd0, mem_ren});
        check_value({tag, " reset mem_wen"}, 32'd0, {31'd0, mem_wen});
        rst_n = 1'b1;
    endtask

    task automatic check_retire(input int row, input string tag);
        logic exp_we;
        string name;
        exp_we = prog_dst[row] != 0;
        name = $sformatf("%s row %0d", tag, row);
        check_value({name, " wb_pc"}, RESET_PC + word_t'(row * 4), wb_pc);
        check_value({name, " rf_we"}, {31'd0, exp_we}, {31'd0, rf_we});
        if (exp_we) begin
            check_value({name, " rf_waddr"}, word_t'(prog_dst[row]), {27'd0, rf_waddr});
            check_value({name, " rf_wdata"}, prog_value[row], rf_wdata);
        end
    endtask

    task automatic run_program(input bit random_ok, input string tag);
        int cycles;
        int pos;
        int stall_cycles;
        cycles = 0;
        pos = 0;
        stall_cycles = 0;
        while (pos < exp_rows.size() && cycles < prog_instr.size() * 8) begin
            @(posedge clk);
            #1;
            cycles++;
            if (stallF) begin
                stall_cycles++;
            end
            if (wb_valid) begin
                check_retire(exp_rows[pos], tag);
                pos++;
            end
            if ((mem_ren || mem_wen) && mem_addr[31:6] != 26'd0) begin
                errors++;
                $display("%s: data access at %h falls outside the memory model", tag, mem_addr);
            end
            if (random_ok) begin
                i_data_ok = ($random(seed) & 3) != 0;
                d_data_ok = ($random(seed) & 3) != 0;
            end
        end
        if (pos < exp_rows.size()) begin
            errors++;
            $display("%s: program did not finish, only %0d of %0d instructions retired",
                     tag, pos, exp_rows.size());
        end
        // with both memories always ready only a load-use holds fetch
        if (!random_ok) begin
            check_value({tag, " stallF cycles"}, word_t'(LOAD_USE_STALLS),
                        word_t'(stall_cycles));
        end
    endtask

    task automatic check_data_memory(input string tag);
        for (int i = 0; i < 16; i++) begin
            check_value($sformatf("%s dmem[%0d]", tag, i), dmem_expect[i[3:0]], dmem[i[3:0]]);
        end
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        i_data_ok = 1'b1;
        d_data_ok = 1'b1;
        build_program();
        apply_reset("stall-free");
        run_program(1'b0, "stall-free");
        check_data_memory("stall-free");
        // same program again with random memory drops
        apply_reset("random stall");
        run_program(1'b1, "random stall");
        check_data_memory("random stall");
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired, the simulation ran too long");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: mips_core.f
common/mips_pkg.sv
hdl/regfile.sv
hdl/hazard_unit.sv
pipeline/fetch_stage.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/memory_stage.sv
hdl/mips_core.sv
tb/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mips_core -Mdir obj_dir -o sim_tb -f mips_core.f \
    && ./obj_dir/sim_tb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^TB PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
